// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // Architectural widths for RV32I
  localparam int XLEN     = 32;
  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;

  // Register value, immediate or ALU result
  typedef logic [XLEN-1:0] word_t;
  // Register index x0..x31
  typedef logic [REG_AW-1:0] reg_addr_t;

  // Major opcodes handled by this execute path
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 encodings shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 values; ALT selects SUB and SRA
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // LUI result is the U immediate
  } alu_op_e;

  // Decoded instruction fields and controls
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    logic      use_imm;
    logic      use_rs1;
    alu_op_e   alu_op;
    logic      wr_en;
    logic      illegal;
  } dec_t;

  // Retire stage contents, also the write port source
  typedef struct packed {
    reg_addr_t rd;
    word_t     result;
    logic      wr_en;
    logic      illegal;
  } retire_t;

endpackage

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

// Integer register file, two async reads and one sync write
module rv_regfile
  import rv_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  // Source operand ports
  input  wire reg_addr_t rs1_addr,
  input  wire reg_addr_t rs2_addr,
  output word_t          rs1_data,
  output word_t          rs2_data,
  // Destination write port
  input  wire            rd_en,
  input  wire reg_addr_t rd_addr,
  input  wire word_t     rd_data
);

  word_t regs [NUM_REGS];

  // One read port: x0 is zero, a same-cycle write wins over the array
  function automatic word_t read_port(
    input reg_addr_t addr,
    input word_t     stored,
    input logic      wr,
    input reg_addr_t waddr,
    input word_t     wdata
  );
    if (addr == '0) begin
      return '0;
    end
    // Bypass so the next instruction sees the retiring value
    if (wr && (waddr == addr)) begin
      return wdata;
    end
    return stored;
  endfunction

  assign rs1_data = read_port(rs1_addr, regs[rs1_addr], rd_en, rd_addr, rd_data);
  assign rs2_data = read_port(rs2_addr, regs[rs2_addr], rd_en, rd_addr, rd_data);

  // All entries clear on reset; x0 is never written afterwards
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Entry zero holds zero for the whole run once reset has been seen
  a_x0_zero: assert property (
    @(posedge clk) disable iff (!rst_n) regs[0] == '0
  ) else $error("rv_regfile: x0 storage became nonzero");

endmodule

`default_nettype wire

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

// RV32I decode for OP, OP-IMM and LUI
module rv_decoder
  import rv_pkg::*;
(
  input  wire word_t instr,
  output dec_t       dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;

  // Fixed instruction fields
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // I-type immediate, sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  // U-type immediate in the upper 20 bits
  assign imm_u = {instr[31:12], 12'b0};

  // Base funct3 to ALU op; SUB and SRA are picked by the caller
  function automatic alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      F3_ADD:  return ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec         = '0;
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.rd      = instr[11:7];
    dec.alu_op  = ALU_ADD;
    case (opcode)
      OPC_OP: begin
        dec.use_rs1 = 1'b1;
        if (funct7 == F7_BASE) begin
          dec.alu_op = base_op(funct3);
          dec.wr_en  = 1'b1;
        end else if ((funct7 == F7_ALT) && (funct3 == F3_ADD)) begin
          dec.alu_op = ALU_SUB;
          dec.wr_en  = 1'b1;
        end else if ((funct7 == F7_ALT) && (funct3 == F3_SR)) begin
          dec.alu_op = ALU_SRA;
          dec.wr_en  = 1'b1;
        end else begin
          // Unlisted funct7 or funct3 pairing
          dec.illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        dec.use_rs1 = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        // Shift immediates reuse bits 31:25 as funct7
        if ((funct3 == F3_SLL) && (funct7 != F7_BASE)) begin
          dec.illegal = 1'b1;
        end else if ((funct3 == F3_SR) && (funct7 == F7_ALT)) begin
          dec.alu_op = ALU_SRA;
          dec.wr_en  = 1'b1;
        end else if ((funct3 == F3_SR) && (funct7 != F7_BASE)) begin
          dec.illegal = 1'b1;
        end else begin
          dec.alu_op = base_op(funct3);
          dec.wr_en  = 1'b1;
        end
      end
      OPC_LUI: begin
        // rs1 field is immediate here, so the operand is forced to zero
        dec.use_imm = 1'b1;
        dec.imm     = imm_u;
        dec.alu_op  = ALU_PASS_B;
        dec.wr_en   = 1'b1;
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
    // No branch above may both flag and write
    a_no_wr_illegal: assert final (!(dec.illegal && dec.wr_en))
      else $error("rv_decoder: illegal encoding requests a write");
  end

endmodule

`default_nettype wire

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

// Integer ALU for the RV32I register and immediate ops
module rv_alu
  import rv_pkg::*;
(
  input  wire alu_op_e op,
  input  wire word_t   a,
  input  wire word_t   b,
  output word_t        result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Only the low five bits of b count for shifts
  assign shamt = b[4:0];

  // Comparisons feeding SLT and SLTU
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      // Set-less-than returns 0 or 1
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:    result = word_t'($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/rv_exec_core.sv ====
`timescale 1ns/1ns
`default_nettype none

// Execute path: decode, read and ALU in one cycle, retire in the next
module rv_exec_core
  import rv_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  // Instruction in
  input  wire        instr_valid,
  input  wire word_t instr,
  // Retire out, one cycle after instr_valid
  output logic       retire_valid,
  output retire_t    retire
);

  dec_t    dec;
  word_t   rs1_data;
  word_t   rs2_data;
  word_t   op_a;
  word_t   op_b;
  word_t   alu_result;
  retire_t retire_next;
  logic    rd_en;

  rv_decoder u_decoder (
    .instr (instr),
    .dec   (dec)
  );

  // Write port comes only from the retire stage
  assign rd_en = retire_valid & retire.wr_en;

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (dec.rs1),
    .rs2_addr (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_en    (rd_en),
    .rd_addr  (retire.rd),
    .rd_data  (retire.result)
  );

  // Operand select; LUI drops rs1
  assign op_a = dec.use_rs1 ? rs1_data : '0;
  assign op_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu u_alu (
    .op     (dec.alu_op),
    .a      (op_a),
    .b      (op_b),
    .result (alu_result)
  );

  // Illegal encodings report a zero result
  always_comb begin
    retire_next.rd      = dec.rd;
    retire_next.result  = dec.illegal ? '0 : alu_result;
    retire_next.wr_en   = dec.wr_en;
    retire_next.illegal = dec.illegal;
  end

  // Retire strobe follows instr_valid by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= instr_valid;
    end
  end

  // Payload only moves with a valid instruction
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      retire <= retire_next;
    end
  end

  // No retire may leak out of a reset cycle
  a_no_retire_after_rst: assert property (
    @(posedge clk) !rst_n |=> !retire_valid
  ) else $error("rv_exec_core: retire_valid high right after reset");

endmodule

`default_nettype wire

// ==== dv/tb_rv_exec_core.sv ====
`timescale 1ns/1ns
`default_nettype none

// Testbench for the execute core against a reference register model
module tb_rv_exec_core
  import rv_pkg::*;
();

  // RV32I major opcodes for building instruction words
  localparam logic [6:0] OPC_R = 7'h33;
  localparam logic [6:0] OPC_I = 7'h13;
  localparam logic [6:0] OPC_U = 7'h37;
  localparam int RESET_CYCLES = 5;
  // Upper bound on pushed instructions over all tests
  localparam int NUM_INSTR = 640;
  localparam int WATCHDOG_NS = NUM_INSTR * 20 * 4 + RESET_CYCLES * 20;
  // Immediate edge values zero, -1, one, 31, max positive and min negative
  localparam logic [11:0] IMM_EDGE [6] = '{12'h000, 12'hfff, 12'h001, 12'h01f, 12'h7ff, 12'h800};

  logic    clk;
  logic    rst_n;
  logic    instr_valid;
  word_t   instr;
  logic    retire_valid;
  retire_t retire;

  word_t   ref_regs [32];
  retire_t exp_q [$];
  retire_t exp_head;
  logic    exp_have;
  string   test_name;
  integer  seed;
  int      value_errs;
  int      timing_errs;
  int      order_errs;

  rv_exec_core u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Retire strobe mirrors instr_valid one cycle later
  a_retire_timing: assert property (
    @(posedge clk) disable iff (!rst_n) retire_valid == $past(instr_valid)
  ) else begin
    timing_errs++;
    $display("retire_valid did not follow instr_valid by one cycle in %s", test_name);
  end

  // Every retire needs an instruction waiting for it
  a_retire_pending: assert property (
    @(posedge clk) disable iff (!rst_n) retire_valid |-> exp_have
  ) else begin
    order_errs++;
    $display("A retire came out with no instruction pending in %s", test_name);
  end

  a_retire_value: assert property (
    @(posedge clk) disable iff (!rst_n) (retire_valid && exp_have) |-> retire == exp_head
  ) else begin
    value_errs++;
    $display("[ERROR] %s: expected %h actual %h", test_name, $sampled(exp_head),
             $sampled(retire));
  end

  function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_R};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_I};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_U};
  endfunction

  // ALU rule by funct3; alt picks SUB or SRA
  function automatic word_t calc(input logic [2:0] f3, input logic alt,
                                 input word_t a, input word_t b);
    case (f3)
      3'd0: calc = alt ? a - b : a + b;
      3'd1: calc = a << b[4:0];
      3'd2: calc = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: calc = (a < b) ? 32'd1 : 32'd0;
      3'd4: calc = a ^ b;
      3'd5: begin
        if (alt) begin
          calc = word_t'($signed(a) >>> b[4:0]);
        end else begin
          calc = a >> b[4:0];
        end
      end
      3'd6: calc = a | b;
      default: calc = a & b;
    endcase
  endfunction

  // Expected retire for one instruction, then commit it to the model
  function automatic retire_t model_exec(input word_t ins);
    retire_t    r;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      res;
    logic       bad;
    f3  = ins[14:12];
    f7  = ins[31:25];
    bad = 1'b0;
    res = '0;
    if (ins[6:0] == OPC_R) begin
      bad = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
      res = calc(f3, f7[5], ref_regs[ins[19:15]], ref_regs[ins[24:20]]);
    end else if (ins[6:0] == OPC_I) begin
      // Only the shifts give meaning to the upper immediate bits
      if (f3 == 3'd1) begin
        bad = (f7 != 7'h00);
      end else if (f3 == 3'd5) begin
        bad = (f7 != 7'h00) && (f7 != 7'h20);
      end
      res = calc(f3, (f3 == 3'd5) && f7[5], ref_regs[ins[19:15]],
                 {{20{ins[31]}}, ins[31:20]});
    end else if (ins[6:0] == OPC_U) begin
      res = {ins[31:12], 12'h000};
    end else begin
      bad = 1'b1;
    end
    r.rd      = ins[11:7];
    r.result  = bad ? '0 : res;
    r.wr_en   = !bad;
    r.illegal = bad;
    // x0 is never written, so reads of it stay zero
    if (!bad && (r.rd != 5'd0)) begin
      ref_regs[r.rd] = res;
    end
    return r;
  endfunction

  // Random word biased toward legal encodings with registers x0..x7
  function automatic word_t rand_instr();
    word_t raw;
    word_t sel;
    raw = $random(seed);
    sel = $random(seed);
    case (sel[1:0])
      2'd0: rand_instr = {1'b0, sel[2], 5'd0, 2'd0, raw[22:20], 2'd0, raw[17:15],
                          raw[14:12], 2'd0, raw[9:7], OPC_R};
      2'd1: rand_instr = {sel[3] ? raw[31:25] : {1'b0, sel[4], 5'd0}, raw[24:20], 2'd0,
                          raw[17:15], raw[14:12], 2'd0, raw[9:7], OPC_I};
      2'd2: rand_instr = {raw[31:12], 2'd0, raw[9:7], OPC_U};
      default: rand_instr = raw;
    endcase
  endfunction

  // One cycle of stimulus on the falling edge
  task automatic step(input logic valid, input word_t ins);
    @(negedge clk);
    // Queue head belongs to the instruction retiring in this cycle
    if (retire_valid && (exp_q.size() > 0)) begin
      exp_head = exp_q.pop_front();
      exp_have = 1'b1;
    end else begin
      exp_have = 1'b0;
    end
    instr_valid = valid;
    instr       = ins;
    if (valid) begin
      exp_q.push_back(model_exec(ins));
    end
  endtask

  initial begin
    seed        = 32'h979e;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    exp_have    = 1'b0;
    value_errs  = 0;
    timing_errs = 0;
    order_errs  = 0;
    test_name   = "reset";
    foreach (ref_regs[i]) begin
      ref_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // x1 sign bit, x2 all ones, x3 zero, x4 shift of 31
    test_name = "load_constants";
    step(1'b1, enc_u(20'h80000, 5'd1));
    step(1'b1, enc_i(12'hfff, 5'd0, 3'd0, 5'd2));
    step(1'b1, enc_i(12'h000, 5'd0, 3'd0, 5'd3));
    step(1'b1, enc_i(12'd31, 5'd0, 3'd0, 5'd4));
    step(1'b1, enc_i(12'h800, 5'd0, 3'd0, 5'd5));
    step(1'b1, enc_u(20'h12345, 5'd6));
    step(1'b1, enc_i(12'h678, 5'd6, 3'd0, 5'd6));

    test_name = "alu_edge_cases";
    for (int s1 = 1; s1 <= 4; s1++) begin
      for (int s2 = 1; s2 <= 4; s2++) begin
        for (int f = 0; f < 8; f++) begin
          step(1'b1, enc_r(7'h00, s2[4:0], s1[4:0], f[2:0], 5'd10));
        end
        step(1'b1, enc_r(7'h20, s2[4:0], s1[4:0], 3'd0, 5'd10));
        step(1'b1, enc_r(7'h20, s2[4:0], s1[4:0], 3'd5, 5'd10));
      end
      for (int k = 0; k < 6; k++) begin
        for (int f = 0; f < 8; f++) begin
          // Shift immediates keep funct7 zero
          if ((f == 1) || (f == 5)) begin
            step(1'b1, enc_i({7'h00, IMM_EDGE[k][4:0]}, s1[4:0], f[2:0], 5'd11));
          end else begin
            step(1'b1, enc_i(IMM_EDGE[k], s1[4:0], f[2:0], 5'd11));
          end
        end
        step(1'b1, enc_i({7'h20, IMM_EDGE[k][4:0]}, s1[4:0], 3'd5, 5'd11));
      end
    end

    // Each instruction reads the rd written just before it
    test_name = "forwarding";
    step(1'b1, enc_i(12'd1, 5'd0, 3'd0, 5'd7));
    repeat (9) step(1'b1, enc_r(7'h00, 5'd7, 5'd7, 3'd0, 5'd7));
    step(1'b1, enc_i(12'hfff, 5'd7, 3'd4, 5'd7));
    repeat (9) step(1'b1, enc_r(7'h20, 5'd2, 5'd7, 3'd0, 5'd7));

    // A retiring x0 write must not reach the next read of x0
    test_name = "x0_writes";
    step(1'b1, enc_i(12'd123, 5'd2, 3'd0, 5'd0));
    step(1'b1, enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
    step(1'b1, enc_u(20'hfffff, 5'd0));
    step(1'b1, enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd9));

    // x12 must keep 77 through the rejected encodings
    test_name = "illegal";
    step(1'b1, enc_i(12'd77, 5'd0, 3'd0, 5'd12));
    step(1'b1, {20'h0, 5'd12, 7'h03});
    step(1'b1, enc_r(7'h01, 5'd2, 5'd12, 3'd0, 5'd12));
    step(1'b1, enc_i(12'h401, 5'd12, 3'd1, 5'd12));
    step(1'b1, enc_i(12'h201, 5'd12, 3'd5, 5'd12));
    step(1'b1, enc_r(7'h00, 5'd0, 5'd12, 3'd0, 5'd13));

    test_name = "random_stream";
    repeat (200) begin
      if (($random(seed) & 3) == 0) begin
        step(1'b0, '0);
      end
      step(1'b1, rand_instr());
    end
    repeat (3) step(1'b0, '0);

    a_queue_empty: assert (exp_q.size() == 0) else begin
      order_errs++;
      $display("%0d instructions never retired", exp_q.size());
    end
    $display("Errors: value=%0d timing=%0d order=%0d", value_errs, timing_errs, order_errs);
    if ((value_errs + timing_errs + order_errs) == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog sized from the instruction budget
  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out before all tests finished");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_exec_core.sv
dv/tb_rv_exec_core.sv

// ==== Makefile ====
# Verilator flow for the RV32I execute core

VERILATOR ?= verilator
TB_TOP    ?= tb_rv_exec_core
RTL_TOP   ?= rv_exec_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing --assert

RTL_SRCS  ?= logic/rv_pkg.sv logic/rv_regfile.sv logic/rv_decoder.sv \
             logic/rv_alu.sv logic/rv_exec_core.sv

.PHONY: all lint sim clean

all: sim

# Lint the design alone, then the design with its testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
